// ==== design/bridge_settings.svh ====
// axi4-lite to apb bridge widths, slave map and timeout
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// bus widths
`define ADDR_W          32
`define DATA_W          32
`define STRB_W          4

// slave map
`define NUM_SLAVES      4
`define SLAVE_IDX_W     2
`define OFFSET_W        8  // 256 byte region per slave
`define TAG_W           (`ADDR_W - `SLAVE_IDX_W - `OFFSET_W)
`define BASE_TAG        22'h000100  // 0x0004_0000 .. 0x0004_03ff

// access cycles without pready before the bridge gives up
`define TIMEOUT_CYCLES  10

`endif

// ==== design/axi_lite_pkg.sv ====
// axi4-lite side types shared by the front end and the apb sequencer
`default_nettype none

`include "bridge_settings.svh"

package axi_lite_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // front end to sequencer
  typedef struct packed {
    logic               write;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic [`STRB_W-1:0] strb;
  } xfer_req_t;

  // sequencer back to front end
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
    resp_e              resp;
  } xfer_rsp_t;

endpackage

`default_nettype wire

// ==== design/apb_pkg.sv ====
// apb side types for the address map and slave responses
`default_nettype none

`include "bridge_settings.svh"

package apb_pkg;

  typedef struct packed {
    logic [`TAG_W-1:0]       tag;     // must match base tag
    logic [`SLAVE_IDX_W-1:0] idx;
    logic [`OFFSET_W-1:0]    offset;
  } apb_addr_fields_t;

  // same word seen as a flat address or as its decode fields
  typedef union packed {
    logic [`ADDR_W-1:0] raw;
    apb_addr_fields_t   fld;
  } apb_addr_u;

  // what one slave drives back
  typedef struct packed {
    logic [`DATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_slv_rsp_t;

  // response of the addressed slave, as seen by the sequencer
  typedef struct packed {
    logic [`DATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               miss;    // no region matched
  } apb_sel_rsp_t;

endpackage

`default_nettype wire

// ==== design/axi_lite_slave.sv ====
// axi4-lite slave front end, captures one transfer and holds its response
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module axi_lite_slave (
  input  logic                    s_axi_clk,
  input  logic                    s_axi_aresetn,
  input  logic [`ADDR_W-1:0]      awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`DATA_W-1:0]      wdata,
  input  logic [`STRB_W-1:0]      wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`ADDR_W-1:0]      araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`DATA_W-1:0]      rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    req,
  output axi_lite_pkg::xfer_req_t xfer_req,
  input  logic                    ack,
  input  axi_lite_pkg::xfer_rsp_t xfer_rsp
);

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    REQUEST,
    RESPOND
  } state_e;

  state_e                  state;
  logic                    live;      // first cycle out of reset seen
  logic                    aw_held;
  logic                    w_held;
  logic                    is_write;
  logic [`ADDR_W-1:0]      addr_q;
  logic [`DATA_W-1:0]      wdata_q;
  logic [`STRB_W-1:0]      strb_q;
  axi_lite_pkg::xfer_rsp_t rsp_q;
  logic                    idle_open;
  logic                    collecting;
  logic                    ar_fire;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    aw_done;
  logic                    w_done;
  logic                    rsp_taken;

  assign idle_open  = live && (state == IDLE);
  assign collecting = (idle_open && !arvalid) || (state == COLLECT);  // read wins in idle

  assign arready = idle_open;
  assign awready = collecting && !aw_held;
  assign wready  = collecting && !w_held;

  assign ar_fire   = arvalid && arready;
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign aw_done   = aw_held || aw_fire;
  assign w_done    = w_held || w_fire;
  assign rsp_taken = (bvalid && bready) || (rvalid && rready);

  always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      state    <= IDLE;
      live     <= 1'b0;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      is_write <= 1'b0;
      req      <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      live <= 1'b1;
      case (state)
        IDLE, COLLECT: begin
          if (ar_fire) begin
            is_write <= 1'b0;
            req      <= 1'b1;
            state    <= REQUEST;
          end else if (aw_done && w_done) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            is_write <= 1'b1;
            req      <= 1'b1;
            state    <= REQUEST;
          end else if (aw_fire || w_fire) begin
            aw_held <= aw_done;  // one half in, wait for the other
            w_held  <= w_done;
            state   <= COLLECT;
          end
        end
        REQUEST: begin
          if (ack) begin
            req    <= 1'b0;
            bvalid <= is_write;
            rvalid <= !is_write;
            state  <= RESPOND;
          end
        end
        RESPOND: begin
          if (rsp_taken) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge s_axi_clk) begin
    if (ar_fire) begin
      addr_q <= araddr;
    end else if (aw_fire) begin
      addr_q <= awaddr;
    end
    if (w_fire) begin
      wdata_q <= wdata;
      strb_q  <= wstrb;
    end
    if (state == REQUEST && ack) begin
      rsp_q <= xfer_rsp;
    end
  end

  assign xfer_req = '{write: is_write, addr: addr_q, wdata: wdata_q, strb: strb_q};

  assign bresp = rsp_q.resp;
  assign rresp = rsp_q.resp;
  assign rdata = rsp_q.rdata;

  // four-phase link, a new request waits for the previous ack to drop
  a_req_after_ack_low : assert property (
    @(posedge s_axi_clk) disable iff (!s_axi_aresetn)
    $rose(req) |-> !ack
  );

endmodule

`default_nettype wire

// ==== design/apb_master.sv ====
// apb sequencer, one setup/access transfer per request with wait-state timeout
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module apb_master (
  input  logic                    s_axi_clk,
  input  logic                    s_axi_aresetn,
  input  logic                    req,
  input  axi_lite_pkg::xfer_req_t xfer_req,
  output logic                    ack,
  output axi_lite_pkg::xfer_rsp_t xfer_rsp,
  output apb_pkg::apb_addr_u      addr,
  output logic                    active,
  input  apb_pkg::apb_sel_rsp_t   sel_rsp,
  output logic [`ADDR_W-1:0]      paddr,
  output logic                    pwrite,
  output logic [`DATA_W-1:0]      pwdata,
  output logic [`STRB_W-1:0]      pstrb,
  output logic                    penable
);

  localparam int TMO_W = $clog2(`TIMEOUT_CYCLES);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    DONE
  } state_e;

  state_e           state;
  logic [TMO_W-1:0] wait_cnt;
  logic             start;
  logic             miss_start;
  logic             timed_out;
  logic             access_end;

  // decoder looks at the pending request while still idle
  assign addr.raw = xfer_req.addr;

  assign active     = (state == SETUP) || (state == ACCESS);
  assign start      = (state == IDLE) && req && !ack;
  assign miss_start = start && sel_rsp.miss;
  assign timed_out  = (wait_cnt == TMO_W'(`TIMEOUT_CYCLES - 1));
  assign access_end = (state == ACCESS) && (sel_rsp.pready || timed_out);

  always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      state    <= IDLE;
      ack      <= 1'b0;
      penable  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (miss_start) begin
            ack   <= 1'b1;  // decerr, no apb cycle
            state <= DONE;
          end else if (start) begin
            state <= SETUP;
          end
        end
        SETUP: begin
          penable  <= 1'b1;
          wait_cnt <= '0;
          state    <= ACCESS;
        end
        ACCESS: begin
          if (access_end) begin
            penable <= 1'b0;
            ack     <= 1'b1;
            state   <= DONE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        DONE: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge s_axi_clk) begin
    if (start) begin
      paddr  <= xfer_req.addr;
      pwrite <= xfer_req.write;
      pwdata <= xfer_req.wdata;
      pstrb  <= xfer_req.write ? xfer_req.strb : '0;  // apb4 wants zero strobes on reads
    end
    if (miss_start) begin
      xfer_rsp <= '{rdata: '0, resp: axi_lite_pkg::DECERR};
    end else if (state == ACCESS && sel_rsp.pready) begin
      xfer_rsp <= '{
        rdata: sel_rsp.prdata,
        resp:  sel_rsp.pslverr ? axi_lite_pkg::SLVERR : axi_lite_pkg::OKAY
      };
    end else if (access_end) begin
      xfer_rsp <= '{rdata: '0, resp: axi_lite_pkg::SLVERR};  // stalled slave
    end
  end

  a_penable_in_transfer : assert property (
    @(posedge s_axi_clk) disable iff (!s_axi_aresetn)
    penable |-> active
  );

  // address and write payload fixed from setup through the last access cycle
  a_payload_stable : assert property (
    @(posedge s_axi_clk) disable iff (!s_axi_aresetn)
    penable |-> $stable({paddr, pwrite, pwdata})
  );

endmodule

`default_nettype wire

// ==== design/apb_slave_decoder.sv ====
// apb region decoder, raises psel and returns the addressed slave's response
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module apb_slave_decoder (
  input  apb_pkg::apb_addr_u    addr,
  input  logic                  active,
  input  apb_pkg::apb_slv_rsp_t slv_rsp [`NUM_SLAVES],
  output logic [`NUM_SLAVES-1:0] psel,
  output apb_pkg::apb_sel_rsp_t sel_rsp
);

  logic                  hit;
  apb_pkg::apb_slv_rsp_t picked;

  assign hit    = (addr.fld.tag == `BASE_TAG);
  assign picked = slv_rsp[addr.fld.idx];

  always_comb begin
    psel = '0;
    if (active && hit) begin
      psel[addr.fld.idx] = 1'b1;
    end
  end

  assign sel_rsp = '{
    prdata:  picked.prdata,
    pready:  picked.pready,
    pslverr: picked.pslverr,
    miss:    !hit
  };

  // never two slaves at once, and never a slave for a missed address
  always_comb begin
    a_psel_onehot : assert ($onehot0(psel) && !((|psel) && sel_rsp.miss));
  end

endmodule

`default_nettype wire

// ==== design/axi_apb_bridge.sv ====
// axi4-lite to apb bridge top level
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module axi_apb_bridge (
  input  logic                    s_axi_clk,
  input  logic                    s_axi_aresetn,
  input  logic [`ADDR_W-1:0]      s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [`DATA_W-1:0]      s_axi_wdata,
  input  logic [`STRB_W-1:0]      s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [`ADDR_W-1:0]      s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [`DATA_W-1:0]      s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  output logic [`ADDR_W-1:0]      m_apb_paddr,
  output logic [`NUM_SLAVES-1:0]  m_apb_psel,
  output logic                    m_apb_penable,
  output logic                    m_apb_pwrite,
  output logic [`DATA_W-1:0]      m_apb_pwdata,
  output logic [`STRB_W-1:0]      m_apb_pstrb,
  input  apb_pkg::apb_slv_rsp_t   m_apb_rsp [`NUM_SLAVES]
);

  logic                    req;
  logic                    ack;
  axi_lite_pkg::xfer_req_t xfer_req;
  axi_lite_pkg::xfer_rsp_t xfer_rsp;
  apb_pkg::apb_addr_u      apb_addr;
  logic                    apb_active;
  apb_pkg::apb_sel_rsp_t   sel_rsp;

  axi_lite_slave i_axi_lite_slave (
    .s_axi_clk     (s_axi_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .req           (req),
    .xfer_req      (xfer_req),
    .ack           (ack),
    .xfer_rsp      (xfer_rsp)
  );

  apb_master i_apb_master (
    .s_axi_clk     (s_axi_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .req           (req),
    .xfer_req      (xfer_req),
    .ack           (ack),
    .xfer_rsp      (xfer_rsp),
    .addr          (apb_addr),
    .active        (apb_active),
    .sel_rsp       (sel_rsp),
    .paddr         (m_apb_paddr),
    .pwrite        (m_apb_pwrite),
    .pwdata        (m_apb_pwdata),
    .pstrb         (m_apb_pstrb),
    .penable       (m_apb_penable)
  );

  apb_slave_decoder i_apb_slave_decoder (
    .addr    (apb_addr),
    .active  (apb_active),
    .slv_rsp (m_apb_rsp),
    .psel    (m_apb_psel),
    .sel_rsp (sel_rsp)
  );

endmodule

`default_nettype wire

// ==== test/apb_slave_mem.sv ====
// behavioural apb slave memories with random wait states and error and stall offsets
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module apb_slave_mem (
  input  logic                   s_axi_clk,
  input  logic                   s_axi_aresetn,
  input  logic [`ADDR_W-1:0]     paddr,
  input  logic [`NUM_SLAVES-1:0] psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`DATA_W-1:0]     pwdata,
  input  logic [`STRB_W-1:0]     pstrb,
  input  logic [1:0]             wait_states,  // picked per transfer by the testbench
  output apb_pkg::apb_slv_rsp_t  rsp [`NUM_SLAVES]
);

  apb_pkg::apb_addr_u a;

  assign a.raw = paddr;

  function automatic logic [`DATA_W-1:0] initial_word(input logic [`ADDR_W-1:0] addr);
    return (addr + (addr << 16)) ^ 32'hA5C3_0F96;
  endfunction

  for (genvar s = 0; s < `NUM_SLAVES; s++) begin : g_slave
    logic [`DATA_W-1:0] mem [64];
    logic [1:0]         wait_cnt;
    logic               stall;
    logic               ready;
    logic               err;

    assign stall  = (s == 3) && (a.fld.offset == 8'h7C);  // slave 3 hangs here
    assign ready  = (wait_cnt == 2'd0) && !stall;
    assign err    = a.fld.offset[7];
    assign rsp[s] = '{prdata: mem[a.fld.offset[7:2]], pready: ready, pslverr: err};

    always @(posedge s_axi_clk or negedge s_axi_aresetn) begin
      if (!s_axi_aresetn) begin
        wait_cnt <= 2'd0;
        for (int w = 0; w < 64; w++) begin
          mem[w] <= initial_word({`BASE_TAG, 2'(s), 6'(w), 2'b00});
        end
      end else begin
        if (psel[s] && !penable) begin
          wait_cnt <= wait_states;  // setup phase
        end else if (psel[s] && wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end
        if (psel[s] && penable && pwrite && ready && !err) begin
          for (int b = 0; b < `STRB_W; b++) begin
            if (pstrb[b]) begin
              mem[a.fld.offset[7:2]][8*b +: 8] <= pwdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_axi_apb_bridge.sv ====
// testbench for the axi4-lite to apb bridge with random traffic checked against a memory model
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module tb_axi_apb_bridge;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_HOLD     = 7;  // longest ready back-pressure
  localparam int N_RANDOM     = 24;
  localparam int N_BACKPRESS  = 8;
  localparam int NUM_XFERS    = 2 * N_RANDOM + 12 + 6 + 4 + 8 + 2 * N_BACKPRESS;
  localparam int CYCLE_LIMIT  =
    NUM_XFERS * (`TIMEOUT_CYCLES + 10 + MAX_HOLD) + RESET_CYCLES;

  logic                  s_axi_clk;
  logic                  s_axi_aresetn;
  logic [`ADDR_W-1:0]    s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  logic [`DATA_W-1:0]    s_axi_wdata;
  logic [`STRB_W-1:0]    s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  logic [1:0]            s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [`ADDR_W-1:0]    s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  logic [`DATA_W-1:0]    s_axi_rdata;
  logic [1:0]            s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  logic [`ADDR_W-1:0]    m_apb_paddr;
  logic [`NUM_SLAVES-1:0] m_apb_psel;
  logic                  m_apb_penable;
  logic                  m_apb_pwrite;
  logic [`DATA_W-1:0]    m_apb_pwdata;
  logic [`STRB_W-1:0]    m_apb_pstrb;
  apb_pkg::apb_slv_rsp_t m_apb_rsp [`NUM_SLAVES];
  logic [1:0]            wait_states;

  logic [`DATA_W-1:0] model_mem [`NUM_SLAVES][64];
  logic [15:0]        lfsr;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;
  int                 b_count = 0;
  int                 psel_count = 0;
  int                 setup_count = 0;

  logic [`NUM_SLAVES-1:0] seen_psel;  // last apb access cycle
  logic [`ADDR_W-1:0]     seen_paddr;
  logic                   seen_pwrite;
  logic [`DATA_W-1:0]     seen_pwdata;
  logic [`STRB_W-1:0]     seen_pstrb;

  initial s_axi_clk = 1'b0;
  always #10 s_axi_clk = ~s_axi_clk;

  axi_apb_bridge i_axi_apb_bridge (
    .s_axi_clk     (s_axi_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .m_apb_paddr   (m_apb_paddr),
    .m_apb_psel    (m_apb_psel),
    .m_apb_penable (m_apb_penable),
    .m_apb_pwrite  (m_apb_pwrite),
    .m_apb_pwdata  (m_apb_pwdata),
    .m_apb_pstrb   (m_apb_pstrb),
    .m_apb_rsp     (m_apb_rsp)
  );

  apb_slave_mem i_apb_slave_mem (
    .s_axi_clk     (s_axi_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .paddr         (m_apb_paddr),
    .psel          (m_apb_psel),
    .penable       (m_apb_penable),
    .pwrite        (m_apb_pwrite),
    .pwdata        (m_apb_pwdata),
    .pstrb         (m_apb_pstrb),
    .wait_states   (wait_states),
    .rsp           (m_apb_rsp)
  );

  always @(posedge s_axi_clk) begin
    cycles <= cycles + 1;
    if (s_axi_bvalid && s_axi_bready) begin
      b_count <= b_count + 1;
    end
    if (|m_apb_psel) begin
      psel_count <= psel_count + 1;
    end
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with a transfer still open", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  always @(negedge s_axi_clk) begin
    if (|m_apb_psel && !m_apb_penable) begin
      setup_count <= setup_count + 1;
    end
    if (|m_apb_psel && m_apb_penable) begin
      seen_psel   <= m_apb_psel;
      seen_paddr  <= m_apb_paddr;
      seen_pwrite <= m_apb_pwrite;
      seen_pwdata <= m_apb_pwdata;
      seen_pstrb  <= m_apb_pstrb;
    end
  end

  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return (addr + (addr << 16)) ^ 32'hA5C3_0F96;
  endfunction

  function automatic logic [1:0] expected_resp(input logic [31:0] addr);
    if (addr[31:10] != `BASE_TAG) begin
      return 2'b11;
    end
    if (addr[7] || (addr[9:8] == 2'd3 && addr[7:0] == 8'h7C)) begin
      return 2'b10;
    end
    return 2'b00;
  endfunction

  // read data is meaningful unless decode missed or the slave stalled
  function automatic bit data_valid(input logic [31:0] addr);
    return (addr[31:10] == `BASE_TAG) && !(addr[9:8] == 2'd3 && addr[7:0] == 8'h7C);
  endfunction

  function automatic logic [31:0] random_addr();
    logic [1:0] idx;
    logic [4:0] word;
    idx  = 2'(rand_bits(2));
    word = 5'(rand_bits(5));
    if (idx == 2'd3 && word == 5'd31) begin
      word = 5'd30;  // keep clear of the stall offset
    end
    return {`BASE_TAG, idx, 1'b0, word, 2'b00};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("failure at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic reset_outputs_low();
    check_val("s_axi_awready", 32'(s_axi_awready), 0);
    check_val("s_axi_wready", 32'(s_axi_wready), 0);
    check_val("s_axi_arready", 32'(s_axi_arready), 0);
    check_val("s_axi_bvalid", 32'(s_axi_bvalid), 0);
    check_val("s_axi_rvalid", 32'(s_axi_rvalid), 0);
    check_val("m_apb_psel", 32'(m_apb_psel), 0);
    check_val("m_apb_penable", 32'(m_apb_penable), 0);
  endtask

  // one setup cycle, then the access cycles carry the transfer's address and payload
  task automatic compare_apb_transfer(input logic [31:0] addr, input bit write,
                                      input logic [31:0] data, input logic [3:0] strb,
                                      input int setup_before);
    check_val("setup cycles", setup_count - setup_before, 1);
    check_val("m_apb_psel", 32'(seen_psel), 32'(1) << addr[9:8]);
    check_val("m_apb_paddr", seen_paddr, addr);
    check_val("m_apb_pwrite", 32'(seen_pwrite), 32'(write));
    if (write) begin
      check_val("m_apb_pwdata", seen_pwdata, data);
      check_val("m_apb_pstrb", 32'(seen_pstrb), 32'(strb));
    end
  endtask

  task automatic drive_aw(input logic [31:0] addr);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    do begin
      @(negedge s_axi_clk);
    end while (!s_axi_awready);
    @(posedge s_axi_clk);
    #2;
    s_axi_awvalid = 1'b0;
  endtask

  task automatic drive_w(input logic [31:0] data, input logic [3:0] strb);
    s_axi_wdata  = data;
    s_axi_wstrb  = strb;
    s_axi_wvalid = 1'b1;
    do begin
      @(negedge s_axi_clk);
    end while (!s_axi_wready);
    @(posedge s_axi_clk);
    #2;
    s_axi_wvalid = 1'b0;
  endtask

  task automatic drive_ar(input logic [31:0] addr);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do begin
      @(negedge s_axi_clk);
    end while (!s_axi_arready);
    @(posedge s_axi_clk);
    #2;
    s_axi_arvalid = 1'b0;
  endtask

  task automatic check_held(input bit is_read, input logic [1:0] resp, input logic [31:0] data);
    if (is_read) begin
      check_val("rvalid", 32'(s_axi_rvalid), 1);
      check_val("rresp", 32'(s_axi_rresp), 32'(resp));
      check_val("rdata", s_axi_rdata, data);
    end else begin
      check_val("bvalid", 32'(s_axi_bvalid), 1);
      check_val("bresp", 32'(s_axi_bresp), 32'(resp));
    end
  endtask

  task automatic set_ready(input bit is_read, input logic value);
    if (is_read) begin
      s_axi_rready = value;
    end else begin
      s_axi_bready = value;
    end
  endtask

  // waits for B or R, keeps ready low for hold cycles, then accepts
  task automatic take_response(input bit is_read, input int hold,
                               output logic [1:0] resp, output logic [31:0] data);
    do begin
      @(negedge s_axi_clk);
    end while (!(is_read ? s_axi_rvalid : s_axi_bvalid));
    resp = is_read ? s_axi_rresp : s_axi_bresp;
    data = s_axi_rdata;
    repeat (hold) begin
      @(negedge s_axi_clk);
      check_held(is_read, resp, data);
    end
    @(posedge s_axi_clk);
    #2;
    set_ready(is_read, 1'b1);
    @(negedge s_axi_clk);
    check_held(is_read, resp, data);
    @(posedge s_axi_clk);
    #2;
    set_ready(is_read, 1'b0);
  endtask

  // order 0 sends AW first, 1 sends W first, 2 sends both together
  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int order, input int hold);
    logic [1:0]  exp;
    logic [1:0]  resp;
    logic [31:0] unused;
    int          b_before;
    int          psel_before;
    int          setup_before;
    exp          = expected_resp(addr);
    b_before     = b_count;
    psel_before  = psel_count;
    setup_before = setup_count;
    wait_states  = 2'(rand_bits(2));
    case (order)
      0: begin
        drive_aw(addr);
        drive_w(data, strb);
      end
      1: begin
        drive_w(data, strb);
        drive_aw(addr);
      end
      default: begin
        fork
          drive_aw(addr);
          drive_w(data, strb);
        join
      end
    endcase
    take_response(1'b0, hold, resp, unused);
    check_val("bresp", 32'(resp), 32'(exp));
    check_val("b handshakes", b_count - b_before, 1);
    check_val("bvalid", 32'(s_axi_bvalid), 0);
    if (exp == 2'b11) begin
      check_true(psel_count == psel_before, "psel raised for an address outside the bridge");
    end else begin
      compare_apb_transfer(addr, 1'b1, data, strb, setup_before);
    end
    if (exp == 2'b00) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (strb[b]) begin
          model_mem[addr[9:8]][addr[7:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic do_read(input logic [31:0] addr, input int hold);
    logic [1:0]  exp;
    logic [1:0]  resp;
    logic [31:0] data;
    int          psel_before;
    int          setup_before;
    exp          = expected_resp(addr);
    psel_before  = psel_count;
    setup_before = setup_count;
    wait_states  = 2'(rand_bits(2));
    drive_ar(addr);
    take_response(1'b1, hold, resp, data);
    check_val("rresp", 32'(resp), 32'(exp));
    if (data_valid(addr)) begin
      check_val("rdata", data, model_mem[addr[9:8]][addr[7:2]]);
    end
    if (exp == 2'b11) begin
      check_true(psel_count == psel_before, "psel raised for an address outside the bridge");
    end else begin
      compare_apb_transfer(addr, 1'b0, '0, '0, setup_before);
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
    end
  endtask

  initial begin
    int          e;
    int          order;
    int          hold;
    logic [1:0]  idx;
    logic [4:0]  word;
    logic [3:0]  strb;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] outside [4];
    lfsr          = 16'd74;
    s_axi_aresetn = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    wait_states   = 2'd0;
    for (int s = 0; s < `NUM_SLAVES; s++) begin
      for (int w = 0; w < 64; w++) begin
        model_mem[s][w] = initial_word({`BASE_TAG, 2'(s), 6'(w), 2'b00});
      end
    end
    repeat (RESET_CYCLES) @(posedge s_axi_clk);
    #2;
    s_axi_aresetn = 1'b1;

    e = errors;
    reset_outputs_low();
    for (int i = 0; i < N_RANDOM; i++) begin
      a    = random_addr();
      d    = rand_bits(32);
      strb = 4'(rand_bits(4));
      do_write(a, d, strb, 0, 0);
      do_read(a, 0);
    end
    end_test(1, "random write and read back", e);

    e = errors;
    for (int round = 0; round < 2; round++) begin
      for (int o = 0; o < 3; o++) begin
        a    = random_addr();
        d    = rand_bits(32);
        strb = 4'(rand_bits(4));
        do_write(a, d, strb, o, 0);
        do_read(a, 0);
      end
    end
    end_test(2, "aw and w ordering", e);

    e = errors;
    for (int i = 0; i < 3; i++) begin
      idx  = 2'(rand_bits(2));
      word = 5'(rand_bits(5));
      a    = {`BASE_TAG, idx, 1'b1, word, 2'b00};  // offset bit 7 set
      d    = rand_bits(32);
      do_write(a, d, 4'hF, 0, 0);
      do_read(a, 0);
    end
    end_test(3, "pslverr offsets", e);

    e = errors;
    a = {`BASE_TAG, 2'd3, 8'h7C};
    do_read(a, 0);
    d = rand_bits(32);
    do_write(a, d, 4'hF, 2, 0);
    a = {`BASE_TAG, 2'd3, 8'h78};
    d = rand_bits(32);
    do_write(a, d, 4'hF, 0, 0);
    do_read(a, 0);
    end_test(4, "stalled slave timeout", e);

    e = errors;
    outside[0] = 32'h0003_FFFC;
    outside[1] = 32'h0004_0400;
    outside[2] = 32'h0000_0000;
    a          = rand_bits(32);
    outside[3] = {1'b1, a[30:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      d = rand_bits(32);
      do_write(outside[i], d, 4'hF, 2, 0);
      do_read(outside[i], 0);
    end
    end_test(5, "decode miss", e);

    e = errors;
    for (int i = 0; i < N_BACKPRESS; i++) begin
      a     = random_addr();
      d     = rand_bits(32);
      strb  = 4'(rand_bits(4));
      order = int'(rand_bits(2)) % 3;
      hold  = int'(rand_bits(3));
      do_write(a, d, strb, order, hold);
      hold = int'(rand_bits(3));
      do_read(a, hold);
    end
    end_test(6, "response back-pressure", e);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/axi_lite_pkg.sv
design/apb_pkg.sv
design/axi_lite_slave.sv
design/apb_master.sv
design/apb_slave_decoder.sv
design/axi_apb_bridge.sv
test/apb_slave_mem.sv
test/tb_axi_apb_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and scan the log for the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f filelist.f --top-module tb_axi_apb_bridge -Mdir obj_dir

./obj_dir/Vtb_axi_apb_bridge > sim.log 2>&1 || true
cat sim.log

if grep -qx 'All tests passed!' sim.log; then
  exit 0
fi
exit 1
